// File: compile.f
+incdir+include
design/core_pkg.sv
design/ctrl_if.sv
design/inst_decoder.sv
design/reg_file.sv
design/alu.sv
design/pc_unit.sv
design/rv_core_top.sv
tests/tb_core.sv

// File: run_sim.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f compile.f --top-module tb_core -o tb_core &&
./obj_dir/tb_core | tee /dev/stderr | grep -q "All tests passed" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: tests/tb_core.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module tb_core;

    localparam int W              = `CORE_WORD_LEN;
    localparam int TIMEOUT_CYCLES = 400;   // Rounded up from 5 tests x (8 reset + 64 words)
    localparam logic [W-1:0] TAKEN_MARK = 32'h1A5;
    localparam logic [W-1:0] NOT_MARK   = 32'h2C3;

    logic         clk;
    logic         rst_n;
    logic [W-1:0] imem_addr, imem_inst, dmem_addr, dmem_rdata, dmem_wdata;
    logic         dmem_wen;
    logic         exit_o;
    logic [W-1:0] imem [64];
    logic [W-1:0] dmem [64];
    logic [W-1:0] dmem_image [64];   // Copied into dmem while in reset
    logic [W-1:0] rng_state;
    logic [W-1:0] halt_addr;
    logic [W-1:0] exp_val [$];
    int           exp_idx [$];
    int           prog_len, slot, errors, pass_count, fail_count, cycle_count;

    rv_core_top i_rv_core_top (.clk(clk), .rst_n(rst_n), .imem_addr_o(imem_addr),
                               .imem_inst_i(imem_inst), .dmem_addr_o(dmem_addr),
                               .dmem_rdata_i(dmem_rdata), .dmem_wen_o(dmem_wen),
                               .dmem_wdata_o(dmem_wdata), .exit_o(exit_o));

    assign imem_inst  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (!rst_n) begin
            dmem <= dmem_image;
        end else if (dmem_wen) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the core did not reach ecall within %0d cycles", cycle_count);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic logic [W-1:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [W-1:0] i_type(logic [W-1:0] imm, int rs1, int f3, int rd,
                                            logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [W-1:0] s_type(logic [W-1:0] imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [W-1:0] b_type(logic [W-1:0] imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [W-1:0] j_type(logic [W-1:0] imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [W-1:0] sext12(logic [W-1:0] v);
        return {{20{v[11]}}, v[11:0]};
    endfunction

    function automatic logic [W-1:0] fill_word(int idx);
        return 32'hC0DE_0000 ^ (4 * idx);
    endfunction

    function automatic logic [W-1:0] bool_word(bit c);
        return c ? 32'd1 : 32'd0;
    endfunction

    function automatic logic [W-1:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // bge is taken when not signed less-than
    function automatic bit branch_rule(int f3, logic [W-1:0] a, logic [W-1:0] b);
        case (f3)
            0:       return a == b;
            1:       return a != b;
            4:       return $signed(a) < $signed(b);
            5:       return !($signed(a) < $signed(b));
            6:       return a < b;
            default: return !(a < b);
        endcase
    endfunction

    task automatic emit_inst(logic [W-1:0] w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic emit_ecall();
        halt_addr = 4 * prog_len;
        emit_inst(`CORE_INST_ECALL);
    endtask

    task automatic expect_word(int idx, logic [W-1:0] value);
        exp_idx.push_back(idx);
        exp_val.push_back(value);
    endtask

    // Instruction writes x3, which then goes to the next result word
    task automatic store_result(logic [W-1:0] inst, logic [W-1:0] value);
        emit_inst(inst);
        emit_inst(s_type(128 + 4 * slot, 3, 0));
        expect_word(32 + slot, value);
        slot++;
    endtask

    task automatic begin_test();
        @(posedge clk);
        rst_n <= 1'b0;
        for (int i = 0; i < 64; i++) begin
            imem[i]       = i_type(4 * i, 0, 0, 0, 7'h13);   // Address-tagged nop
            dmem_image[i] = fill_word(i);
        end
        prog_len = 0;
        slot     = 0;
        errors   = 0;
        exp_idx.delete();
        exp_val.delete();
    endtask

    task automatic check_halt();
        if (!exit_o || imem_addr !== halt_addr) begin
            $display("[FAIL] %0t: not halted at %h, exit %b pc %h", $time, halt_addr,
                     exit_o, imem_addr);
            errors++;
        end
    endtask

    task automatic finish_test(string name, int hold);
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        do begin
            @(negedge clk);
        end while (!exit_o);
        check_halt();
        repeat (hold) begin
            @(negedge clk);
            check_halt();
        end
        foreach (exp_idx[k]) begin
            if (dmem[exp_idx[k]] !== exp_val[k]) begin
                $display("[FAIL] %0t: %s dmem[%0d] is %h, expected %h", $time, name,
                         exp_idx[k], dmem[exp_idx[k]], exp_val[k]);
                errors++;
            end
        end
        if (errors == 0) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: %0d errors", name, errors);
        end
    endtask

    task automatic arith_ops();
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W-1:0] imm;
        begin_test();
        a   = next_rand();
        b   = next_rand();
        imm = next_rand() & 32'hFFF;
        dmem_image[0] = a;
        dmem_image[1] = b;
        emit_inst(i_type(0, 0, 2, 1, 7'h03));   // lw x1, 0(x0)
        emit_inst(i_type(4, 0, 2, 2, 7'h03));   // lw x2, 4(x0)
        store_result(r_type(0, 2, 1, 0, 3), a + b);
        store_result(r_type(32, 2, 1, 0, 3), a - b);
        store_result(r_type(0, 2, 1, 7, 3), a & b);
        store_result(r_type(0, 2, 1, 6, 3), a | b);
        store_result(r_type(0, 2, 1, 4, 3), a ^ b);
        store_result(i_type(imm, 1, 0, 3, 7'h13), a + sext12(imm));
        store_result(i_type(imm, 1, 7, 3, 7'h13), a & sext12(imm));
        store_result(i_type(imm, 1, 6, 3, 7'h13), a | sext12(imm));
        store_result(i_type(imm, 1, 4, 3, 7'h13), a ^ sext12(imm));
        emit_ecall();
        finish_test("arith", 0);
    endtask

    task automatic shifts_and_compares();
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W-1:0] sh;
        logic [W-1:0] imm;
        begin_test();
        a   = next_rand() | 32'h8000_0000;   // Negative
        b   = next_rand() & 32'h7FFF_FFFF;   // Upper bits beyond shamt stay set
        sh  = next_rand() & 32'h1F;
        imm = next_rand() & 32'hFFF;
        dmem_image[0] = a;
        dmem_image[1] = b;
        emit_inst(i_type(0, 0, 2, 1, 7'h03));
        emit_inst(i_type(4, 0, 2, 2, 7'h03));
        store_result(r_type(0, 2, 1, 1, 3), a << b[4:0]);
        store_result(r_type(0, 2, 1, 5, 3), a >> b[4:0]);
        store_result(r_type(32, 2, 1, 5, 3), $signed(a) >>> b[4:0]);
        store_result(i_type(sh, 1, 1, 3, 7'h13), a << sh[4:0]);
        store_result(i_type(sh, 1, 5, 3, 7'h13), a >> sh[4:0]);
        store_result(i_type(32'h400 | sh, 1, 5, 3, 7'h13), $signed(a) >>> sh[4:0]);
        store_result(r_type(0, 2, 1, 2, 3), bool_word($signed(a) < $signed(b)));
        store_result(r_type(0, 2, 1, 3, 3), bool_word(a < b));
        store_result(i_type(imm, 1, 2, 3, 7'h13), bool_word($signed(a) < $signed(sext12(imm))));
        store_result(i_type(imm, 1, 3, 3, 7'h13), bool_word(a < sext12(imm)));
        emit_ecall();
        finish_test("shift_cmp", 0);
    endtask

    task automatic branch_case(int f3, int rs1, int rs2, logic [W-1:0] va, logic [W-1:0] vb);
        emit_inst(i_type(TAKEN_MARK, 0, 0, 3, 7'h13));
        emit_inst(b_type(8, rs2, rs1, f3));   // Taken lands on the store
        store_result(i_type(NOT_MARK, 0, 0, 3, 7'h13),
                     branch_rule(f3, va, vb) ? TAKEN_MARK : NOT_MARK);
    endtask

    task automatic branch_conditions();
        logic [W-1:0] n;
        logic [W-1:0] p;
        begin_test();
        n = next_rand() | 32'h8000_0000;
        p = next_rand() & 32'h7FFF_FFFF;
        dmem_image[0] = n;
        dmem_image[1] = p;
        emit_inst(i_type(0, 0, 2, 1, 7'h03));   // x1 negative
        emit_inst(i_type(4, 0, 2, 2, 7'h03));   // x2 positive
        emit_inst(i_type(4, 0, 2, 4, 7'h03));   // x4 equal to x2
        branch_case(0, 2, 4, p, p);
        branch_case(0, 1, 2, n, p);
        branch_case(1, 1, 2, n, p);
        branch_case(1, 2, 4, p, p);
        branch_case(4, 1, 2, n, p);
        branch_case(4, 2, 1, p, n);
        branch_case(5, 2, 1, p, n);
        branch_case(5, 1, 2, n, p);
        branch_case(5, 2, 4, p, p);
        branch_case(6, 2, 1, p, n);
        branch_case(6, 1, 2, n, p);
        branch_case(7, 1, 2, n, p);
        branch_case(7, 2, 1, p, n);
        emit_ecall();
        finish_test("branches", 0);
    endtask

    task automatic jumps_and_links();
        begin_test();
        emit_inst(j_type(8, 1));                 // jal x1, +8 at address 0
        emit_inst(s_type(128, 0, 0));            // Skipped
        emit_inst(s_type(132, 1, 0));
        emit_inst(i_type(21, 0, 0, 2, 7'h13));   // x2 = 21
        emit_inst(i_type(4, 2, 0, 3, 7'h67));    // jalr x3, 4(x2) lands on 24 with bit 0 cleared
        emit_inst(s_type(136, 0, 0));            // Skipped
        emit_inst(s_type(140, 3, 0));
        emit_ecall();
        expect_word(32, fill_word(32));
        expect_word(33, 32'd4);
        expect_word(34, fill_word(34));
        expect_word(35, 32'd20);
        finish_test("jumps", 0);
    endtask

    task automatic x0_and_halt();
        begin_test();
        dmem_image[0] = next_rand() | 32'h1;
        emit_inst(i_type(0, 0, 2, 0, 7'h03));        // lw x0, 0(x0)
        emit_inst(i_type(32'h123, 0, 0, 0, 7'h13));  // addi x0, x0, 0x123
        emit_inst(s_type(128, 0, 0));
        emit_ecall();
        emit_inst(s_type(132, 0, 0));                // Must never commit
        expect_word(32, 32'd0);
        expect_word(33, fill_word(33));
        finish_test("x0_halt", 5);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n      <= 1'b0;
        rng_state   = 32'd79;
        cycle_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        arith_ops();
        shifts_and_compares();
        branch_conditions();
        jumps_and_links();
        x0_and_halt();
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: design/rv_core_top.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module rv_core_top (
    input  logic                      clk,
    input  logic                      rst_n,
    output logic [`CORE_WORD_LEN-1:0] imem_addr_o,
    input  logic [`CORE_WORD_LEN-1:0] imem_inst_i,
    output logic [`CORE_WORD_LEN-1:0] dmem_addr_o,
    input  logic [`CORE_WORD_LEN-1:0] dmem_rdata_i,
    output logic                      dmem_wen_o,
    output logic [`CORE_WORD_LEN-1:0] dmem_wdata_o,
    output logic                      exit_o
);

    logic [`CORE_REG_ADDR_W-1:0] rs1_addr, rs2_addr, rd_addr;
    logic [`CORE_WORD_LEN-1:0]   rs1_data, rs2_data;
    logic [`CORE_WORD_LEN-1:0]   alu_result, pc, pc_plus4;
    logic                        br_taken, halted;

    ctrl_if ctrl ();

    inst_decoder i_inst_decoder (.inst_i(imem_inst_i), .ctrl(ctrl), .rs1_addr_o(rs1_addr),
                                 .rs2_addr_o(rs2_addr), .rd_addr_o(rd_addr));

    reg_file i_reg_file (.clk(clk), .rst_n(rst_n), .halted_i(halted), .rs1_addr_i(rs1_addr),
                         .rs2_addr_i(rs2_addr), .rd_addr_i(rd_addr), .alu_result_i(alu_result),
                         .mem_rdata_i(dmem_rdata_i), .pc_plus4_i(pc_plus4), .wb(ctrl),
                         .rs1_data_o(rs1_data), .rs2_data_o(rs2_data));

    alu i_alu (.ex(ctrl), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .pc_i(pc),
               .result_o(alu_result), .br_taken_o(br_taken));

    pc_unit i_pc_unit (.clk(clk), .rst_n(rst_n), .inst_i(imem_inst_i), .fe(ctrl),
                       .br_taken_i(br_taken), .alu_result_i(alu_result), .pc_o(pc),
                       .pc_plus4_o(pc_plus4), .halted_o(halted));

    assign imem_addr_o  = pc;
    assign dmem_addr_o  = alu_result;
    assign dmem_wdata_o = rs2_data;
    assign dmem_wen_o   = ctrl.mem_wen & rst_n & ~halted;   // No stores in reset or after ecall
    assign exit_o       = halted;

endmodule

// File: design/pc_unit.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module pc_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`CORE_WORD_LEN-1:0] inst_i,
    ctrl_if.fetch                     fe,
    input  logic                      br_taken_i,
    input  logic [`CORE_WORD_LEN-1:0] alu_result_i,
    output logic [`CORE_WORD_LEN-1:0] pc_o,
    output logic [`CORE_WORD_LEN-1:0] pc_plus4_o,
    output logic                      halted_o
);

    logic [`CORE_WORD_LEN-1:0] pc_q;
    logic [`CORE_WORD_LEN-1:0] pc_next;
    logic                      halt_q;

    // Sticky once ecall has been seen
    assign halted_o   = halt_q | (inst_i == `CORE_INST_ECALL);
    assign pc_o       = pc_q;
    assign pc_plus4_o = pc_q + `CORE_WORD_LEN'd4;

    always_comb begin
        if (halted_o) begin
            pc_next = pc_q;
        end else if (fe.is_jump) begin
            pc_next = alu_result_i;               // pc+imm for jal, rs1+imm for jalr
        end else if (fe.is_branch && br_taken_i) begin
            pc_next = pc_q + fe.imm;
        end else begin
            pc_next = pc_plus4_o;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q   <= '0;
            halt_q <= 1'b0;
        end else begin
            pc_q   <= pc_next;
            halt_q <= halted_o;
        end
    end

endmodule

// File: design/alu.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module alu (
    ctrl_if.exec                      ex,
    input  logic [`CORE_WORD_LEN-1:0] rs1_data_i,
    input  logic [`CORE_WORD_LEN-1:0] rs2_data_i,
    input  logic [`CORE_WORD_LEN-1:0] pc_i,
    output logic [`CORE_WORD_LEN-1:0] result_o,
    output logic                      br_taken_o
);

    logic [`CORE_WORD_LEN-1:0] op1;
    logic [`CORE_WORD_LEN-1:0] op2;
    logic [`CORE_WORD_LEN-1:0] sum;
    logic [4:0]                shamt;
    logic                      eq;
    logic                      lt_s;
    logic                      lt_u;

    assign op1   = (ex.op1_sel == core_pkg::OP1_PC) ? pc_i : rs1_data_i;
    assign op2   = (ex.op2_sel == core_pkg::OP2_IMM) ? ex.imm : rs2_data_i;
    assign sum   = op1 + op2;
    assign shamt = op2[4:0];
    assign eq    = (op1 == op2);
    assign lt_s  = ($signed(op1) < $signed(op2));
    assign lt_u  = (op1 < op2);

    always_comb begin
        case (ex.alu_op)
            core_pkg::ALU_SUB:  result_o = op1 - op2;
            core_pkg::ALU_AND:  result_o = op1 & op2;
            core_pkg::ALU_OR:   result_o = op1 | op2;
            core_pkg::ALU_XOR:  result_o = op1 ^ op2;
            core_pkg::ALU_SLL:  result_o = op1 << shamt;
            core_pkg::ALU_SRL:  result_o = op1 >> shamt;
            core_pkg::ALU_SRA:  result_o = $unsigned($signed(op1) >>> shamt);
            core_pkg::ALU_SLT:  result_o = {{(`CORE_WORD_LEN-1){1'b0}}, lt_s};
            core_pkg::ALU_SLTU: result_o = {{(`CORE_WORD_LEN-1){1'b0}}, lt_u};
            core_pkg::ALU_JALR: result_o = {sum[`CORE_WORD_LEN-1:1], 1'b0};
            default:            result_o = sum;   // add, load/store address, jal target
        endcase
    end

    always_comb begin
        case (ex.alu_op)
            core_pkg::ALU_BEQ:  br_taken_o = eq;
            core_pkg::ALU_BNE:  br_taken_o = !eq;
            core_pkg::ALU_BLT:  br_taken_o = lt_s;
            core_pkg::ALU_BGE:  br_taken_o = !lt_s;
            core_pkg::ALU_BLTU: br_taken_o = lt_u;
            core_pkg::ALU_BGEU: br_taken_o = !lt_u;
            default:            br_taken_o = 1'b0;
        endcase
    end

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module reg_file (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        halted_i,
    input  logic [`CORE_REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`CORE_REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [`CORE_REG_ADDR_W-1:0] rd_addr_i,
    input  logic [`CORE_WORD_LEN-1:0]   alu_result_i,
    input  logic [`CORE_WORD_LEN-1:0]   mem_rdata_i,
    input  logic [`CORE_WORD_LEN-1:0]   pc_plus4_i,
    ctrl_if.wback                       wb,
    output logic [`CORE_WORD_LEN-1:0]   rs1_data_o,
    output logic [`CORE_WORD_LEN-1:0]   rs2_data_o
);

    logic [`CORE_WORD_LEN-1:0] regs [`CORE_REG_COUNT];
    logic [`CORE_WORD_LEN-1:0] wb_data;

    always_comb begin
        case (wb.wb_sel)
            core_pkg::WB_MEM: wb_data = mem_rdata_i;
            core_pkg::WB_PC4: wb_data = pc_plus4_i;
            default:          wb_data = alu_result_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.rf_wen && !halted_i && rd_addr_i != '0) begin
            regs[rd_addr_i] <= wb_data;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];   // x0 reads zero
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: design/inst_decoder.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module inst_decoder (
    input  logic [`CORE_WORD_LEN-1:0]   inst_i,
    ctrl_if.decoder                     ctrl,
    output logic [`CORE_REG_ADDR_W-1:0] rs1_addr_o,
    output logic [`CORE_REG_ADDR_W-1:0] rs2_addr_o,
    output logic [`CORE_REG_ADDR_W-1:0] rd_addr_o
);

    core_pkg::opcode_e         opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [`CORE_WORD_LEN-1:0] imm_i;
    logic [`CORE_WORD_LEN-1:0] imm_s;
    logic [`CORE_WORD_LEN-1:0] imm_b;
    logic [`CORE_WORD_LEN-1:0] imm_j;

    assign opcode     = core_pkg::opcode_e'(inst_i[6:0]);
    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];

    assign imm_i = {{(`CORE_WORD_LEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{(`CORE_WORD_LEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{(`CORE_WORD_LEN-13){inst_i[31]}}, inst_i[31], inst_i[7],
                    inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{(`CORE_WORD_LEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                    inst_i[20], inst_i[30:21], 1'b0};

    // Shared by OP and OP_IMM with alt picking sub or sra
    function automatic core_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  arith_op = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  arith_op = core_pkg::ALU_SLL;
            3'b010:  arith_op = core_pkg::ALU_SLT;
            3'b011:  arith_op = core_pkg::ALU_SLTU;
            3'b100:  arith_op = core_pkg::ALU_XOR;
            3'b101:  arith_op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  arith_op = core_pkg::ALU_OR;
            default: arith_op = core_pkg::ALU_AND;
        endcase
    endfunction

    function automatic core_pkg::alu_op_e branch_op(input logic [2:0] f3);
        case (f3)
            3'b000:  branch_op = core_pkg::ALU_BEQ;
            3'b001:  branch_op = core_pkg::ALU_BNE;
            3'b100:  branch_op = core_pkg::ALU_BLT;
            3'b101:  branch_op = core_pkg::ALU_BGE;
            3'b110:  branch_op = core_pkg::ALU_BLTU;
            default: branch_op = core_pkg::ALU_BGEU;
        endcase
    endfunction

    always_comb begin
        // Defaults decode to a harmless pc+4 with no writes
        ctrl.alu_op    = core_pkg::ALU_ADD;
        ctrl.op1_sel   = core_pkg::OP1_RS1;
        ctrl.op2_sel   = core_pkg::OP2_RS2;
        ctrl.imm       = imm_i;
        ctrl.rf_wen    = 1'b0;
        ctrl.mem_wen   = 1'b0;
        ctrl.wb_sel    = core_pkg::WB_ALU;
        ctrl.is_branch = 1'b0;
        ctrl.is_jump   = 1'b0;
        case (opcode)
            core_pkg::OPC_LOAD: begin
                ctrl.op2_sel = core_pkg::OP2_IMM;
                ctrl.wb_sel  = core_pkg::WB_MEM;
                ctrl.rf_wen  = (funct3 == 3'b010);   // lw only
            end
            core_pkg::OPC_STORE: begin
                ctrl.op2_sel = core_pkg::OP2_IMM;
                ctrl.imm     = imm_s;
                ctrl.mem_wen = (funct3 == 3'b010);
            end
            core_pkg::OPC_OP: begin
                ctrl.alu_op = arith_op(funct3, funct7[5]);
                ctrl.rf_wen = (funct7 == 7'b0000000) ||
                              (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            core_pkg::OPC_OP_IMM: begin
                ctrl.alu_op  = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
                ctrl.op2_sel = core_pkg::OP2_IMM;
                // Shift immediates need a clean funct7
                if (funct3 == 3'b001) begin
                    ctrl.rf_wen = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    ctrl.rf_wen = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end else begin
                    ctrl.rf_wen = 1'b1;
                end
            end
            core_pkg::OPC_BRANCH: begin
                ctrl.alu_op    = branch_op(funct3);
                ctrl.imm       = imm_b;
                ctrl.is_branch = (funct3[2:1] != 2'b01);
            end
            core_pkg::OPC_JAL: begin
                ctrl.op1_sel = core_pkg::OP1_PC;      // Target is pc+imm
                ctrl.op2_sel = core_pkg::OP2_IMM;
                ctrl.imm     = imm_j;
                ctrl.wb_sel  = core_pkg::WB_PC4;
                ctrl.rf_wen  = 1'b1;
                ctrl.is_jump = 1'b1;
            end
            core_pkg::OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl.alu_op  = core_pkg::ALU_JALR;
                    ctrl.op2_sel = core_pkg::OP2_IMM;
                    ctrl.wb_sel  = core_pkg::WB_PC4;
                    ctrl.rf_wen  = 1'b1;
                    ctrl.is_jump = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: design/ctrl_if.sv
`timescale 1ns/1ps
`include "core_defines.svh"

interface ctrl_if;

    core_pkg::alu_op_e         alu_op;
    core_pkg::op1_sel_e        op1_sel;
    core_pkg::op2_sel_e        op2_sel;
    logic [`CORE_WORD_LEN-1:0] imm;       // Already sign-extended
    logic                      rf_wen;
    logic                      mem_wen;
    core_pkg::wb_sel_e         wb_sel;
    logic                      is_branch;
    logic                      is_jump;

    modport decoder (
        output alu_op, op1_sel, op2_sel, imm, rf_wen, mem_wen, wb_sel, is_branch, is_jump
    );

    modport exec (input alu_op, op1_sel, op2_sel, imm);

    modport wback (input rf_wen, wb_sel);

    modport fetch (input imm, is_branch, is_jump);

endinterface

// File: design/core_pkg.sv
package core_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_AND  = 5'd2,
        ALU_OR   = 5'd3,
        ALU_XOR  = 5'd4,
        ALU_SLL  = 5'd5,
        ALU_SRL  = 5'd6,
        ALU_SRA  = 5'd7,
        ALU_SLT  = 5'd8,
        ALU_SLTU = 5'd9,
        ALU_BEQ  = 5'd10,   // Branch compares
        ALU_BNE  = 5'd11,
        ALU_BLT  = 5'd12,
        ALU_BGE  = 5'd13,
        ALU_BLTU = 5'd14,
        ALU_BGEU = 5'd15,
        ALU_JALR = 5'd16
    } alu_op_e;

    typedef enum logic {
        OP1_RS1 = 1'b0,
        OP1_PC  = 1'b1
    } op1_sel_e;

    typedef enum logic [1:0] {
        OP2_RS2 = 2'd0,
        OP2_IMM = 2'd1
    } op2_sel_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2       // Link value for jal and jalr
    } wb_sel_e;

endpackage

// File: include/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data and address width
`define CORE_WORD_LEN 32

// Register file geometry
`define CORE_REG_COUNT 32
`define CORE_REG_ADDR_W 5

// Fetching this word halts the core
`define CORE_INST_ECALL 32'h0000_0073

`endif
